// File: src/ising_pkg.sv
// ====================
// Ising energy shared definitions
// ====================

`default_nettype none

package ising_pkg;

    // Problem size
    localparam int NUM_SPIN = 8;
    localparam int NUM_UNIT = 4;
    localparam int NUM_ROUND = NUM_SPIN / NUM_UNIT;

    // Operand and result widths
    localparam int BITJ = 4;
    localparam int BITH = 4;
    localparam int SCALING_BIT = 5;
    localparam int MULTBIT = BITH + SCALING_BIT - 1;
    localparam int LOCAL_ENERGY_BIT = MULTBIT + 3;
    localparam int TOTAL_ENERGY_BIT = LOCAL_ENERGY_BIT + 3;

    typedef logic [NUM_SPIN-1:0] spin_vec_t;
    // One row of J, entry j in bits 4j+3:4j
    typedef logic [NUM_SPIN*BITJ-1:0] j_row_t;
    typedef logic signed [BITH-1:0] hbias_t;
    typedef logic [SCALING_BIT-1:0] hscale_t;
    typedef logic signed [LOCAL_ENERGY_BIT-1:0] local_energy_t;
    typedef logic signed [TOTAL_ENERGY_BIT-1:0] total_energy_t;
    typedef logic [$clog2(NUM_UNIT)-1:0] unit_idx_t;
    typedef logic [0:0] round_idx_t;

    // APB register map
    localparam logic [7:0] ADDR_CTRL = 8'h00;
    localparam logic [7:0] ADDR_SPIN = 8'h04;
    localparam logic [7:0] ADDR_HBIAS = 8'h08;
    localparam logic [7:0] ADDR_STATUS = 8'h0C;
    localparam logic [7:0] ADDR_ENERGY = 8'h10;
    localparam logic [7:0] ADDR_J_BASE = 8'h20;

    // Dispatcher FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } disp_state_e;

endpackage

`default_nettype wire

// File: src/spin_calc_if.sv
// ====================
// Unit operand and result link
// ====================

`timescale 1ns/1ps
`default_nettype none

interface spin_calc_if;
    import ising_pkg::*;

    // Operands, sampled whenever op_valid is high
    logic op_valid;
    spin_vec_t spin_vector;
    logic current_spin;
    j_row_t weight_row;
    hbias_t hbias;
    hscale_t hscaling;

    // Local energy of one spin
    local_energy_t energy;
    logic energy_valid;

    modport disp (output op_valid, spin_vector, current_spin, weight_row, hbias, hscaling);
    modport unit (
        input op_valid, spin_vector, current_spin, weight_row, hbias, hscaling,
        output energy, energy_valid
    );
    modport acc (input energy, energy_valid);

endinterface

`default_nettype wire

// File: src/ising_apb_regs.sv
// ====================
// Ising APB register file
// ====================

`timescale 1ns/1ps
`default_nettype none

module ising_apb_regs (
    input  logic clk_i,
    input  logic rst_n_i,
    // APB slave
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  logic [7:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic pready_o,
    output logic pslverr_o,
    // Run operands towards the dispatcher
    output ising_pkg::spin_vec_t spin_o,
    output ising_pkg::j_row_t [ising_pkg::NUM_SPIN-1:0] j_rows_o,
    output ising_pkg::hbias_t [ising_pkg::NUM_SPIN-1:0] hbias_o,
    output ising_pkg::hscale_t hscaling_o,
    output logic start_o,
    output logic busy_o,
    // Result from the accumulator
    input  ising_pkg::total_energy_t energy_i,
    input  logic done_i
);
    import ising_pkg::*;

    logic access;
    logic is_j;
    logic mapped;
    logic guarded;
    logic err;
    logic wr_en;
    logic [$clog2(NUM_SPIN)-1:0] j_idx;

    spin_vec_t spin_q;
    j_row_t [NUM_SPIN-1:0] j_q;
    hbias_t [NUM_SPIN-1:0] hbias_q;
    hscale_t hscale_q;
    total_energy_t energy_q;
    logic busy_q;
    logic done_q;

    // ====================
    // Address decode
    // ====================
    assign access = psel_i & penable_i;
    // J window is 32-byte aligned, so the row index is a plain slice
    assign j_idx = paddr_i[2 +: $clog2(NUM_SPIN)];
    assign is_j = (paddr_i[1:0] == 2'b00)
        && (int'(paddr_i) >= int'(ADDR_J_BASE))
        && (int'(paddr_i) < int'(ADDR_J_BASE) + 4 * NUM_SPIN);

    // Guarded registers must not change under a running evaluation
    always_comb begin
        case (paddr_i)
            ADDR_CTRL, ADDR_SPIN, ADDR_HBIAS: begin
                mapped = 1'b1;
                guarded = 1'b1;
            end
            ADDR_STATUS, ADDR_ENERGY: begin
                mapped = 1'b1;
                guarded = 1'b0;
            end
            default: begin
                mapped = is_j;
                guarded = is_j;
            end
        endcase
    end

    assign err = access & (~mapped | (pwrite_i & guarded & busy_q));
    assign wr_en = access & pwrite_i & ~err;
    assign pslverr_o = err;
    // No wait states
    assign pready_o = 1'b1;

    // Start pulse in the access phase, already blocked while busy by err
    assign start_o = wr_en & (paddr_i == ADDR_CTRL) & pwdata_i[0];

    // Operand registers
    always_ff @(posedge clk_i) begin
        if (wr_en && is_j) j_q[j_idx] <= pwdata_i;
        if (wr_en && paddr_i == ADDR_SPIN) spin_q <= pwdata_i[NUM_SPIN-1:0];
        if (wr_en && paddr_i == ADDR_HBIAS) hbias_q <= pwdata_i;
        if (wr_en && paddr_i == ADDR_CTRL) hscale_q <= pwdata_i[8 +: SCALING_BIT];
    end

    // ====================
    // Run status
    // ====================
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            energy_q <= '0;
        end else if (start_o) begin
            // New run hides the previous result flag
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (done_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
            energy_q <= energy_i;
        end
    end

    // Read mux
    always_comb begin
        prdata_o = '0;
        if (is_j) begin
            prdata_o = j_q[j_idx];
        end else begin
            case (paddr_i)
                ADDR_CTRL: prdata_o = 32'(hscale_q) << 8;
                ADDR_SPIN: prdata_o = 32'(spin_q);
                ADDR_HBIAS: prdata_o = hbias_q;
                ADDR_STATUS: prdata_o = {30'b0, done_q, busy_q};
                // Sign extension to the bus width
                ADDR_ENERGY: prdata_o = 32'(energy_q);
                default: prdata_o = '0;
            endcase
        end
    end

    assign spin_o = spin_q;
    assign j_rows_o = j_q;
    assign hbias_o = hbias_q;
    assign hscaling_o = hscale_q;
    assign busy_o = busy_q;

endmodule

`default_nettype wire

// File: src/energy_dispatcher.sv
// ====================
// Round dispatcher
// ====================

`timescale 1ns/1ps
`default_nettype none

module energy_dispatcher #(
    parameter int PIPES = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  ising_pkg::spin_vec_t spin_i,
    input  ising_pkg::j_row_t [ising_pkg::NUM_SPIN-1:0] j_rows_i,
    input  ising_pkg::hbias_t [ising_pkg::NUM_SPIN-1:0] hbias_i,
    input  ising_pkg::hscale_t hscaling_i,
    spin_calc_if.disp calc_if [ising_pkg::NUM_UNIT]
);
    import ising_pkg::*;

    disp_state_e state_q;
    round_idx_t round_q;
    // Drain counter for the unit pipeline
    logic [$clog2(PIPES+1):0] wait_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            round_q <= '0;
            wait_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= ISSUE;
                        round_q <= '0;
                    end
                end
                ISSUE: begin
                    round_q <= round_q + 1'b1;
                    if (round_q == round_idx_t'(NUM_ROUND - 1)) begin
                        state_q <= (PIPES == 0) ? IDLE : WAIT;
                        wait_q <= '0;
                    end
                end
                WAIT: begin
                    wait_q <= wait_q + 1'b1;
                    if (int'(wait_q) == PIPES - 1) state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // ====================
    // Operand issue
    // ====================
    // Unit k of round r handles spin r*NUM_UNIT + k
    for (genvar k = 0; k < NUM_UNIT; k++) begin : g_issue
        logic [$clog2(NUM_SPIN)-1:0] spin_idx;

        assign spin_idx = {round_q, unit_idx_t'(k)};
        assign calc_if[k].op_valid = (state_q == ISSUE);
        assign calc_if[k].spin_vector = spin_i;
        assign calc_if[k].current_spin = spin_i[spin_idx];
        assign calc_if[k].weight_row = j_rows_i[spin_idx];
        assign calc_if[k].hbias = hbias_i[spin_idx];
        assign calc_if[k].hscaling = hscaling_i;
    end

endmodule

`default_nettype wire

// File: src/adder_tree.sv
// ====================
// Pipelined signed adder tree
// ====================

`timescale 1ns/1ps
`default_nettype none

module adder_tree #(
    parameter int N = 8,
    parameter int DATAW = 8,
    parameter int PIPES = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic [N-1:0][DATAW-1:0] data_i,
    output logic signed [DATAW+$clog2(N)-1:0] sum_o
);
    localparam int LEVELS = $clog2(N);
    localparam int OUTW = DATAW + LEVELS;

    // Heap layout, root at 0 and leaves at N-1 .. 2N-2
    logic signed [OUTW-1:0] node [2*N-1];

    // Leaves, sign extended to the full result width
    for (genvar i = 0; i < N; i++) begin : g_leaf
        assign node[N-1+i] = OUTW'($signed(data_i[i]));
    end

    // Inner nodes
    // Level counted from the leaves, 1 at the first adders
    // A level gets a register where PIPES*level/LEVELS steps up
    for (genvar i = 0; i < N - 1; i++) begin : g_node
        localparam int LVL = LEVELS - ($clog2(i + 2) - 1);
        localparam bit REG = (LVL * PIPES / LEVELS) != ((LVL - 1) * PIPES / LEVELS);

        logic signed [OUTW-1:0] sum;

        assign sum = node[2*i+1] + node[2*i+2];

        if (REG) begin : g_reg
            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    node[i] <= '0;
                end else begin
                    node[i] <= sum;
                end
            end
        end else begin : g_comb
            assign node[i] = sum;
        end
    end

    assign sum_o = node[0];

endmodule

`default_nettype wire

// File: src/partial_energy_calc.sv
// ====================
// Local energy of one spin
// ====================

`timescale 1ns/1ps
`default_nettype none

module partial_energy_calc #(
    parameter int PIPES = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    spin_calc_if.unit calc_if
);
    import ising_pkg::*;

    logic [NUM_SPIN-1:0][MULTBIT-1:0] mult_out;
    logic signed [MULTBIT-1:0] h_ext;
    logic signed [MULTBIT-1:0] h_scaled;
    logic [2:0] h_shift;
    logic signed [LOCAL_ENERGY_BIT-1:0] tree_sum;
    logic signed [LOCAL_ENERGY_BIT-1:0] local_sum;

    // Delay lines, tap 0 is the issue cycle
    logic valid_dly [PIPES+1];
    logic spin_dly [PIPES+1];
    logic signed [MULTBIT-1:0] h_dly [PIPES+1];

    // s_j * J_ij, a spin bit of 0 negates the entry
    always_comb begin
        for (int j = 0; j < NUM_SPIN; j++) begin
            logic signed [MULTBIT-1:0] w;
            w = MULTBIT'($signed(calc_if.weight_row[j*BITJ +: BITJ]));
            mult_out[j] = calc_if.spin_vector[j] ? w : -w;
        end
    end

    adder_tree #(
        .N(NUM_SPIN),
        .DATAW(MULTBIT),
        .PIPES(PIPES)
    ) i_tree (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .data_i(mult_out),
        .sum_o(tree_sum)
    );

    // Power-of-two scale as a shift, other values fall back to 1
    always_comb begin
        case (calc_if.hscaling)
            5'd2: h_shift = 3'd1;
            5'd4: h_shift = 3'd2;
            5'd8: h_shift = 3'd3;
            5'd16: h_shift = 3'd4;
            default: h_shift = 3'd0;
        endcase
    end

    assign h_ext = MULTBIT'(calc_if.hbias);
    assign h_scaled = h_ext <<< h_shift;

    // ====================
    // Tree alignment
    // ====================
    assign valid_dly[0] = calc_if.op_valid;
    assign spin_dly[0] = calc_if.current_spin;
    assign h_dly[0] = h_scaled;

    for (genvar p = 0; p < PIPES; p++) begin : g_dly
        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                valid_dly[p+1] <= 1'b0;
            end else begin
                valid_dly[p+1] <= valid_dly[p];
            end
        end

        always_ff @(posedge clk_i) begin
            spin_dly[p+1] <= spin_dly[p];
            h_dly[p+1] <= h_dly[p];
        end
    end

    // Add bias then apply s_i
    assign local_sum = tree_sum + LOCAL_ENERGY_BIT'(h_dly[PIPES]);
    assign calc_if.energy = spin_dly[PIPES] ? local_sum : -local_sum;
    assign calc_if.energy_valid = valid_dly[PIPES];

endmodule

`default_nettype wire

// File: src/energy_accumulator.sv
// ====================
// Total energy accumulator
// ====================

`timescale 1ns/1ps
`default_nettype none

module energy_accumulator #(
    parameter int PIPES = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    spin_calc_if.acc calc_if [ising_pkg::NUM_UNIT],
    output ising_pkg::total_energy_t energy_o,
    output logic done_o
);
    import ising_pkg::*;

    local_energy_t unit_e [NUM_UNIT];
    logic [NUM_UNIT-1:0] unit_v;
    total_energy_t round_sum;
    total_energy_t total_q;
    round_idx_t round_q;
    logic done_q;
    logic armed_q;
    logic accept;

    for (genvar k = 0; k < NUM_UNIT; k++) begin : g_tap
        assign unit_e[k] = calc_if[k].energy;
        assign unit_v[k] = calc_if[k].energy_valid;
    end

    // Sum of the valid units in this cycle
    always_comb begin
        round_sum = '0;
        for (int k = 0; k < NUM_UNIT; k++) begin
            if (unit_v[k]) round_sum = round_sum + TOTAL_ENERGY_BIT'(unit_e[k]);
        end
    end

    // Unit results only count inside a run
    assign accept = armed_q && (|unit_v);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            total_q <= '0;
            round_q <= '0;
            done_q <= 1'b0;
            armed_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                total_q <= '0;
                round_q <= '0;
                armed_q <= 1'b1;
            end else if (accept) begin
                total_q <= total_q + round_sum;
                round_q <= round_q + 1'b1;
                // Last round in, one-cycle done pulse
                if (round_q == round_idx_t'(NUM_ROUND - 1)) begin
                    done_q <= 1'b1;
                    armed_q <= 1'b0;
                end
            end
        end
    end

    assign energy_o = total_q;
    assign done_o = done_q;

endmodule

`default_nettype wire

// File: src/ising_energy_top.sv
// ====================
// Ising energy evaluator top
// ====================

`timescale 1ns/1ps
`default_nettype none

module ising_energy_top #(
    parameter int PIPES = 1
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic psel_i,
    input  logic penable_i,
    input  logic pwrite_i,
    input  logic [7:0] paddr_i,
    input  logic [31:0] pwdata_i,
    output logic [31:0] prdata_o,
    output logic pready_o,
    output logic pslverr_o,
    output logic done_o
);
    import ising_pkg::*;

    spin_vec_t spin;
    j_row_t [NUM_SPIN-1:0] j_rows;
    hbias_t [NUM_SPIN-1:0] hbias;
    hscale_t hscaling;
    logic start;
    logic acc_done;
    logic done_q;
    total_energy_t energy;

    // One link per unit
    spin_calc_if calc_if [NUM_UNIT] ();

    ising_apb_regs i_regs (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .spin_o(spin),
        .j_rows_o(j_rows),
        .hbias_o(hbias),
        .hscaling_o(hscaling),
        .start_o(start),
        .busy_o(),
        .energy_i(energy),
        .done_i(acc_done)
    );

    energy_dispatcher #(
        .PIPES(PIPES)
    ) i_disp (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .start_i(start),
        .spin_i(spin),
        .j_rows_i(j_rows),
        .hbias_i(hbias),
        .hscaling_i(hscaling),
        .calc_if(calc_if)
    );

    for (genvar k = 0; k < NUM_UNIT; k++) begin : g_unit
        partial_energy_calc #(
            .PIPES(PIPES)
        ) i_unit (
            .clk_i(clk_i),
            .rst_n_i(rst_n_i),
            .calc_if(calc_if[k])
        );
    end

    energy_accumulator #(
        .PIPES(PIPES)
    ) i_acc (
        .clk_i(clk_i),
        .rst_n_i(rst_n_i),
        .start_i(start),
        .calc_if(calc_if),
        .energy_o(energy),
        .done_o(acc_done)
    );

    // Pulse in step with the STATUS done bit
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= acc_done;
        end
    end

    assign done_o = done_q;

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// ====================
// Testbench clock and reset
// ====================

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);
    // Free-running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset low for the first few edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: test/ising_energy_chk.sv
// ====================
// APB and run assertions
// ====================

`timescale 1ns/1ps
`default_nettype none

module ising_energy_chk (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic psel_i,
    input  logic penable_i,
    input  logic start_i,
    input  logic busy_i,
    input  logic done_i
);
    // Access phase only after a setup phase
    apb_setup_first: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        penable_i |-> $past(psel_i) && !$past(penable_i))
        else $error("APB access phase without a preceding setup phase");

    // Status bits exclusive
    busy_done_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(busy_i && done_i))
        else $error("Busy and done are both set");

    // No new run while one is in flight
    start_idle_only: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(start_i && busy_i))
        else $error("Start pulse while busy");

endmodule

bind ising_apb_regs ising_energy_chk i_chk (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .psel_i(psel_i),
    .penable_i(penable_i),
    .start_i(start_o),
    .busy_i(busy_q),
    .done_i(done_q)
);

`default_nettype wire

// File: test/tb_ising_energy.sv
// ====================
// Ising energy testbench
// ====================

`timescale 1ns/1ps
`default_nettype none

module tb_ising_energy;
    import ising_pkg::*;

    localparam int PIPES = 1;
    localparam int NUM_RUNS = 8;
    // Latency run and the two busy runs
    localparam int EXTRA_RUNS = 3;
    localparam int RUN_BASE = NUM_SPIN;
    localparam int TIMEOUT_CYCLES = 200 * (NUM_RUNS + EXTRA_RUNS) + 100;
    localparam int MAX_POLLS = 50;

    logic clk;
    logic rst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic done;

    // J rows, then spin, h word, scale, energy per run
    logic [31:0] tdata [RUN_BASE + 4 * NUM_RUNS];
    logic [31:0] run_energy [NUM_RUNS];
    integer seed;
    int mismatches;
    int failures;

    tb_clk_gen #(
        .PERIOD_NS(8),
        .RESET_CYCLES(2)
    ) i_clk_gen (
        .clk_o(clk),
        .rst_n_o(rst_n)
    );

    ising_energy_top #(
        .PIPES(PIPES)
    ) i_ising_energy_top (
        .clk_i(clk),
        .rst_n_i(rst_n),
        .psel_i(psel),
        .penable_i(penable),
        .pwrite_i(pwrite),
        .paddr_i(paddr),
        .pwdata_i(pwdata),
        .prdata_o(prdata),
        .pready_o(pready),
        .pslverr_o(pslverr),
        .done_o(done)
    );

    // ====================
    // Bus and check helpers
    // ====================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        // Mid access phase
        @(negedge clk);
        err = pslverr;
        check_value("PREADY", {31'b0, pready}, 32'd1);
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    // Operands of run r, then CTRL with scale and start bit
    task automatic start_run(input int r);
        logic err;
        write_reg(ADDR_SPIN, tdata[RUN_BASE + 4 * r], err);
        check_value("SPIN write PSLVERR", {31'b0, err}, 32'd0);
        write_reg(ADDR_HBIAS, tdata[RUN_BASE + 4 * r + 1], err);
        check_value("HBIAS write PSLVERR", {31'b0, err}, 32'd0);
        write_reg(ADDR_CTRL, {19'b0, tdata[RUN_BASE + 4 * r + 2][4:0], 7'b0, 1'b1}, err);
        check_value("start write PSLVERR", {31'b0, err}, 32'd0);
    endtask

    // Poll STATUS until done, then compare ENERGY with the file
    task automatic finish_run(input int r, output logic [31:0] energy);
        logic [31:0] status;
        logic err;
        int polls;
        status = '0;
        polls = 0;
        while (status[1] !== 1'b1 && polls < MAX_POLLS) begin
            read_reg(ADDR_STATUS, status, err);
            polls++;
        end
        if (status[1] !== 1'b1) begin
            failures++;
            $display("Error: run %0d did not report done within %0d status reads", r, polls);
        end
        check_value($sformatf("run %0d STATUS", r), status, 32'h2);
        read_reg(ADDR_ENERGY, energy, err);
        check_value($sformatf("run %0d ENERGY", r), energy, tdata[RUN_BASE + 4 * r + 3]);
    endtask

    function automatic bit scale_valid(input logic [7:0] s);
        return (s == 8'd1) || (s == 8'd2) || (s == 8'd4) || (s == 8'd8) || (s == 8'd16);
    endfunction

    // ====================
    // Watchdog
    // ====================
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    // ====================
    // Main sequence
    // ====================
    initial begin
        logic [31:0] val;
        logic [31:0] rd;
        logic err;
        int cycles;
        logic [7:0] bad_addr [4];

        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mismatches = 0;
        failures = 0;
        seed = 32'h444f0636;
        // Unmapped, past the J window, misaligned in J
        bad_addr[0] = 8'h14;
        bad_addr[1] = 8'h1C;
        bad_addr[2] = 8'h40;
        bad_addr[3] = 8'h22;

        $readmemh("test/ising_testdata.txt", tdata);
        if ($isunknown(tdata[RUN_BASE + 4 * NUM_RUNS - 1])) begin
            failures++;
            $display("Error: the testdata file could not be read completely");
        end

        wait (rst_n === 1'b1);
        @(posedge clk);

        // Reset values
        check_value("done_o after reset", {31'b0, done}, 32'd0);
        read_reg(ADDR_STATUS, rd, err);
        check_value("STATUS after reset", rd, 32'd0);
        read_reg(ADDR_ENERGY, rd, err);
        check_value("ENERGY after reset", rd, 32'd0);

        // Random readback of the operand registers
        for (int i = 0; i < NUM_SPIN; i++) begin
            val = $random(seed);
            write_reg(ADDR_J_BASE + 8'(4 * i), val, err);
            read_reg(ADDR_J_BASE + 8'(4 * i), rd, err);
            check_value($sformatf("J row %0d readback", i), rd, val);
        end
        val = $random(seed);
        write_reg(ADDR_SPIN, val, err);
        read_reg(ADDR_SPIN, rd, err);
        check_value("SPIN readback", rd, {24'b0, val[7:0]});
        val = $random(seed);
        write_reg(ADDR_HBIAS, val, err);
        read_reg(ADDR_HBIAS, rd, err);
        check_value("HBIAS readback", rd, val);

        // Coupling matrix from the file
        for (int i = 0; i < NUM_SPIN; i++) begin
            write_reg(ADDR_J_BASE + 8'(4 * i), tdata[i], err);
            check_value("J write PSLVERR", {31'b0, err}, 32'd0);
            read_reg(ADDR_J_BASE + 8'(4 * i), rd, err);
            check_value($sformatf("J row %0d load", i), rd, tdata[i]);
        end

        // Unmapped addresses
        for (int i = 0; i < 4; i++) begin
            write_reg(bad_addr[i], 32'hFFFF_FFFF, err);
            check_value($sformatf("write to %h PSLVERR", bad_addr[i]), {31'b0, err}, 32'd1);
            read_reg(bad_addr[i], rd, err);
            check_value($sformatf("read of %h PSLVERR", bad_addr[i]), {31'b0, err}, 32'd1);
        end

        // Energy runs from the file
        for (int r = 0; r < NUM_RUNS; r++) begin
            start_run(r);
            finish_run(r, run_energy[r]);
        end

        // Invalid scale must give the expected energy of the same operands at scale 1
        for (int r = 0; r < NUM_RUNS; r++) begin
            if (!scale_valid(tdata[RUN_BASE + 4 * r + 2][7:0])) begin
                for (int q = 0; q < NUM_RUNS; q++) begin
                    if (tdata[RUN_BASE + 4 * q] == tdata[RUN_BASE + 4 * r]
                        && tdata[RUN_BASE + 4 * q + 1] == tdata[RUN_BASE + 4 * r + 1]
                        && tdata[RUN_BASE + 4 * q + 2] == 32'd1) begin
                        check_value($sformatf("run %0d vs scale 1 run %0d", r, q),
                                    run_energy[r], tdata[RUN_BASE + 4 * q + 3]);
                    end
                end
            end
        end

        // done_o latency from the start write edge
        start_run(0);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (done !== 1'b1 && cycles < MAX_POLLS);
        check_value("done_o latency", cycles, PIPES + 3);
        finish_run(0, val);

        // J write while busy is refused and discarded
        start_run(2);
        write_reg(ADDR_J_BASE + 8'd12, 32'h0, err);
        check_value("busy J write PSLVERR", {31'b0, err}, 32'd1);
        finish_run(2, val);
        read_reg(ADDR_J_BASE + 8'd12, rd, err);
        check_value("J row 3 after busy write", rd, tdata[3]);

        // Second start while busy, scale 1 would change the result
        start_run(5);
        write_reg(ADDR_CTRL, 32'h0000_0101, err);
        check_value("busy start PSLVERR", {31'b0, err}, 32'd1);
        finish_run(5, val);
        read_reg(ADDR_CTRL, rd, err);
        check_value("CTRL after busy start", rd,
                    {19'b0, tdata[RUN_BASE + 4 * 5 + 2][4:0], 8'b0});

        $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/ising_testdata.txt
// Lines 1 to 8: J rows 0 to 7, entry J_ij in bits 4j+3:4j
// Then one run per line: spin vector, h word, hscaling, expected total energy
D2F403E1
702C150E
E102AF53
14B32A10
0D1832C4
2961B02F
F39D4102
CF201E7D
000000FF 4D2F03E1 00000001 0000000B
00000000 4D2F03E1 00000004 FFFFFFF7
000000A5 4D2F03E1 00000001 00000007
000000A5 4D2F03E1 00000003 00000007
000000A5 4D2F03E1 00000000 00000007
000000A5 4D2F03E1 00000008 00000077
0000003C 30A25F78 00000010 FFFFFFCF
0000003C 30A25F78 00000002 FFFFFFEB

// File: sim.f
src/ising_pkg.sv
src/spin_calc_if.sv
src/ising_apb_regs.sv
src/energy_dispatcher.sv
src/adder_tree.sv
src/partial_energy_calc.sv
src/energy_accumulator.sv
src/ising_energy_top.sv
test/tb_clk_gen.sv
test/ising_energy_chk.sv
test/tb_ising_energy.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Ising energy testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_ising_energy \
    -f sim.f \
    -o tb_ising_energy

./obj_dir/tb_ising_energy | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Test run failed"
    exit 1
fi
echo "Test run passed"
